// ==== Makefile ====
TOP = corrXy2Tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sim.f rtl/*.sv bench/*.sv
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)

# The log decides the result, the simulator status is ignored
run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/clockGen.sv ====
`timescale 1ns/100ps

module clockGen (
	output logic clk,
	output logic arstN
);

	localparam int HALF_PERIOD = 5;
	localparam int RESET_CYCLES = 2;

	// 10 ns clock, first rising edge at 5 ns
	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Released on a falling edge after two rising edges in reset
	initial
	begin
		arstN = 1'b0;
		#(2 * HALF_PERIOD * RESET_CYCLES) arstN = 1'b1;
	end

endmodule

// ==== bench/corrXy2Tb.sv ====
`timescale 1ns/100ps

module corrXy2Tb import corrPkg::*; ();

	localparam logic [31:0] SEED = 32'h1053bc23;
	// Five runs of at most 400 cycles each plus load and readback
	localparam int RUNS = 5;
	localparam int RUN_CYCLES = 400;
	localparam int LOAD_CYCLES = 160;
	localparam int CYCLE_LIMIT = RUNS * (RUN_CYCLES + LOAD_CYCLES) + 100;
	localparam int TAIL_CYCLES = 8;

	logic clk;
	logic arstN;
	logic start;
	logic memMuxSel;
	logic [ADDR_W-1:0] testReadAddr;
	logic [ADDR_W-1:0] testWriteAddr;
	logic [DATA_W-1:0] testWriteData;
	logic testWriteEn;
	logic done;
	logic [DATA_W-1:0] memData;

	logic signed [15:0] xnVec [SUBFRAME_LEN];
	logic signed [15:0] y1Vec [SUBFRAME_LEN];
	logic signed [15:0] y2Vec [SUBFRAME_LEN];
	logic [31:0] expWords [6];
	int errors = 0;
	int doneCount = 0;
	int cycleCount = 0;

	clockGen clocks (
		.clk(clk),
		.arstN(arstN)
	);

	corrXy2Pipe u_dut (
		.clk(clk),
		.arstN(arstN),
		.start(start),
		.memMuxSel(memMuxSel),
		.testReadAddr(testReadAddr),
		.testWriteAddr(testWriteAddr),
		.testWriteData(testWriteData),
		.testWriteEn(testWriteEn),
		.done(done),
		.memData(memData)
	);

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Term 0 is y2.y2, 1 is xn.y2, 2 is y1.y2
	function automatic logic [31:0] correlate(input int term);
		longint maxSum;
		longint minSum;
		longint acc;
		longint scaled;
		longint partner;
		maxSum = 64'sd2147483647;
		minSum = -maxSum - 1;
		acc = 1;
		for (int i = 0; i < SUBFRAME_LEN; i++)
		begin
			scaled = longint'(y2Vec[i]) >>> Y2_SHIFT;
			if (term == 0)
				partner = scaled;
			else if (term == 1)
				partner = longint'(xnVec[i]);
			else
				partner = longint'(y1Vec[i]);
			acc = acc + 2 * scaled * partner;
			// Saturate after every step
			if (acc > maxSum)
				acc = maxSum;
			else if (acc < minSum)
				acc = minSum;
		end
		return 32'(acc);
	endfunction

	function automatic void normalize(input logic [31:0] value, output int count,
		output logic [31:0] shifted);
		count = 0;
		shifted = value;
		if (value != 32'd0)
		begin
			while (shifted[31] == shifted[30])
			begin
				shifted = shifted << 1;
				count++;
			end
		end
	endfunction

	function automatic void buildExpected();
		logic [31:0] shifted;
		logic [15:0] mant;
		int count;
		int expo;
		int negated;
		for (int t = 0; t < 3; t++)
		begin
			normalize(correlate(t), count, shifted);
			mant = shifted[31:16];
			if (t == 0)
				expo = count - int'(YY_EXP_OFFSET);
			else
			begin
				// Negate in full range and clamp to the 16-bit maximum
				negated = -int'($signed(mant));
				if (negated > 32767)
					negated = 32767;
				mant = 16'(negated);
				expo = count - int'(CROSS_EXP_OFFSET);
			end
			expWords[2 * t] = {{16{mant[15]}}, mant};
			expWords[2 * t + 1] = 32'(expo);
		end
	endfunction

	function automatic string wordName(input int k);
		case (k)
			0: return "mantYy";
			1: return "expYy";
			2: return "mantXy";
			3: return "expXy";
			4: return "mantZy";
			default: return "expZy";
		endcase
	endfunction

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////

	task automatic fillRandom();
		for (int i = 0; i < SUBFRAME_LEN; i++)
		begin
			xnVec[i] = 16'($urandom());
			y1Vec[i] = 16'($urandom());
			y2Vec[i] = 16'($urandom());
		end
	endtask

	task automatic writeWord(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
		testWriteAddr = addr;
		testWriteData = data;
		testWriteEn = 1'b1;
		@(negedge clk);
	endtask

	task automatic loadVectors();
		logic [ADDR_W-1:0] addr;
		@(negedge clk);
		memMuxSel = 1'b1;
		for (int i = 0; i < SUBFRAME_LEN; i++)
		begin
			writeWord(XN_BASE + ADDR_W'(i), {{16{xnVec[i][15]}}, xnVec[i]});
			writeWord(Y1_BASE + ADDR_W'(i), {{16{y1Vec[i][15]}}, y1Vec[i]});
			writeWord(Y2_BASE + ADDR_W'(i), {{16{y2Vec[i][15]}}, y2Vec[i]});
		end
		// Stale words in the result area so that old results cannot match
		for (int k = 0; k < 6; k++)
		begin
			addr = RESULT_BASE + ADDR_W'(k);
			writeWord(addr, 32'hdead_0000 | 32'(addr));
		end
		testWriteEn = 1'b0;
	endtask

	task automatic checkIdle(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			assert (!done && u_dut.fsm.state == idle) else
			begin
				errors++;
				$display("Fail at %0t: done = %b state = %0d, expected done = 0 state = %0d",
					$time, done, u_dut.fsm.state, idle);
			end
		end
	endtask

	// A nonzero midStart pulses start again that many cycles into the run
	task automatic runOnce(input int midStart);
		int cycles;
		int doneBefore;
		bit seen;
		@(negedge clk);
		memMuxSel = 1'b0;
		doneBefore = doneCount;
		start = 1'b1;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < RUN_CYCLES)
		begin
			@(negedge clk);
			cycles++;
			start = (cycles == midStart);
			seen = done;
		end
		start = 1'b0;
		assert (seen) else
		begin
			errors++;
			$display("done did not arrive within %0d cycles", RUN_CYCLES);
		end
		repeat (TAIL_CYCLES) @(negedge clk);
		assert (doneCount == doneBefore + 1) else
		begin
			errors++;
			$display("Fail at %0t: done pulses = %0d, expected 1", $time, doneCount - doneBefore);
		end
		checkIdle(2);
	endtask

	task automatic checkResults(input string label);
		logic [31:0] got;
		@(negedge clk);
		memMuxSel = 1'b1;
		for (int k = 0; k < 6; k++)
		begin
			testReadAddr = RESULT_BASE + ADDR_W'(k);
			@(negedge clk);
			got = memData;
			assert (got == expWords[k]) else
			begin
				errors++;
				$display("Fail at %0t: %s memData %s = %h, expected %h",
					$time, label, wordName(k), got, expWords[k]);
			end
		end
	endtask

	// Model against values worked out by hand
	task automatic checkModelWord(input int k, input logic [31:0] hand);
		assert (expWords[k] == hand) else
		begin
			errors++;
			$display("Fail at %0t: model %s = %h, expected %h", $time, wordName(k), expWords[k], hand);
		end
	endtask

	//////////////////////////////
	// Monitors
	//////////////////////////////

	always @(posedge clk)
	begin
		if (done)
			doneCount <= doneCount + 1;
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, errors so far: %0d", cycleCount, errors);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		void'($urandom(SEED));
		start = 1'b0;
		memMuxSel = 1'b0;
		testReadAddr = '0;
		testWriteAddr = '0;
		testWriteData = '0;
		testWriteEn = 1'b0;
		@(posedge arstN);
		checkIdle(10);

		// Random samples
		fillRandom();
		loadVectors();
		buildExpected();
		checkIdle(3);
		runOnce(0);
		checkResults("random");

		// All samples zero so every sum stays at 1
		for (int i = 0; i < SUBFRAME_LEN; i++)
		begin
			xnVec[i] = 16'sd0;
			y1Vec[i] = 16'sd0;
			y2Vec[i] = 16'sd0;
		end
		loadVectors();
		buildExpected();
		checkModelWord(0, 32'd16384);
		checkModelWord(1, 32'd20);
		checkModelWord(2, 32'hffff_c000);
		checkModelWord(3, 32'd17);
		checkModelWord(4, 32'hffff_c000);
		checkModelWord(5, 32'd17);
		runOnce(0);
		checkResults("zero");

		// Full scale xn and y2 saturate the xy sum
		fillRandom();
		for (int i = 0; i < SUBFRAME_LEN; i++)
		begin
			xnVec[i] = -16'sd32768;
			y2Vec[i] = -16'sd32768;
		end
		loadVectors();
		buildExpected();
		checkModelWord(2, 32'hffff_8001);
		checkModelWord(3, 32'hffff_fff3);
		runOnce(0);
		checkResults("saturation");

		// Two runs back to back with a stray start in the first
		fillRandom();
		loadVectors();
		buildExpected();
		runOnce(60);
		checkResults("first back-to-back");
		fillRandom();
		loadVectors();
		buildExpected();
		runOnce(0);
		checkResults("second back-to-back");

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== bench/corrXy2_properties.sv ====
`timescale 1ns/100ps

module corrXy2Properties import corrPkg::*; (
	input logic clk,
	input logic arstN,
	input logic start,
	input logic done,
	input corrState state,
	input logic memWriteEn,
	input logic [ADDR_W-1:0] memWriteAddr,
	input logic normReady,
	input logic normDone
);

	logic runActive;
	logic normPending;
	int normWaitCycles;

	// Run in progress from an accepted start to its done
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			runActive <= 1'b0;
		else if (state == idle && start)
			runActive <= 1'b1;
		else if (done)
			runActive <= 1'b0;
	end

	// Cycles spent waiting on the normalizer
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			normPending <= 1'b0;
			normWaitCycles <= 0;
		end
		else if (normReady)
		begin
			normPending <= 1'b1;
			normWaitCycles <= 1;
		end
		else if (normDone)
		begin
			normPending <= 1'b0;
			normWaitCycles <= 0;
		end
		else if (normPending)
			normWaitCycles <= normWaitCycles + 1;
	end

	//////////////////////////////
	// Protocol checks
	//////////////////////////////

	assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
		else $error("done stayed high for two cycles");

	assert property (@(posedge clk) disable iff (!arstN) normPending |-> normWaitCycles <= 33)
		else $error("normDone did not follow normReady within 33 cycles");

	assert property (@(posedge clk) disable iff (!arstN) normDone |-> normPending)
		else $error("normDone without a preceding normReady");

	// Result words only
	assert property (@(posedge clk) disable iff (!arstN)
		memWriteEn |-> (memWriteAddr >= RESULT_BASE && memWriteAddr <= RESULT_BASE + ADDR_W'(5)))
		else $error("FSM wrote outside the result area");

	assert property (@(posedge clk) disable iff (!arstN) done |-> runActive)
		else $error("done without a preceding start");

endmodule

bind corrXy2Fsm corrXy2Properties props (
	.clk(clk),
	.arstN(arstN),
	.start(start),
	.done(done),
	.state(state),
	.memWriteEn(memWriteEn),
	.memWriteAddr(memWriteAddr),
	.normReady(normReady),
	.normDone(normDone)
);

// ==== rtl/corrPkg.sv ====
package corrPkg;

	//////////////////////////////
	// Memory geometry
	//////////////////////////////

	localparam int ADDR_W = 12;
	localparam int DATA_W = 32;

	// One subframe of samples per vector
	localparam int SUBFRAME_LEN = 40;
	localparam int IDX_W = $clog2(SUBFRAME_LEN);

	// Vector start addresses, one sign-extended sample per word
	localparam logic [ADDR_W-1:0] XN_BASE = 12'd0;
	localparam logic [ADDR_W-1:0] Y1_BASE = 12'd40;
	localparam logic [ADDR_W-1:0] Y2_BASE = 12'd80;

	// Six result words: yy, xy, zy as mantissa then exponent
	localparam logic [ADDR_W-1:0] RESULT_BASE = 12'd128;

	//////////////////////////////
	// Arithmetic constants
	//////////////////////////////

	// Scaling of y2 ahead of every product
	localparam int Y2_SHIFT = 3;

	// Exponent offsets for the energy term and the cross terms
	localparam logic [5:0] YY_EXP_OFFSET = 6'd10;
	localparam logic [5:0] CROSS_EXP_OFFSET = 6'd13;

	// Control FSM states
	typedef enum logic [3:0] {
		idle,
		readPair,
		waitRead,
		accumulate,
		normStart,
		normWait,
		writeMant,
		writeExp,
		finish
	} corrState;

	// Which correlation the FSM is working on
	typedef enum logic [1:0] {
		termYy,
		termXy,
		termZy
	} corrTerm;

endpackage

// ==== rtl/corrXy2Fsm.sv ====
`timescale 1ns/100ps

module corrXy2Fsm import corrPkg::*; (
	input logic clk,
	input logic arstN,
	input logic start,
	output logic done,
	output logic [ADDR_W-1:0] memReadAddr,
	output logic [ADDR_W-1:0] memWriteAddr,
	output logic [DATA_W-1:0] memWriteData,
	output logic memWriteEn,
	input logic [DATA_W-1:0] memReadData,
	output logic [15:0] shrIn,
	input logic [15:0] shrOut,
	output logic [15:0] macA,
	output logic [15:0] macB,
	output logic [31:0] macAcc,
	input logic [31:0] macOut,
	output logic [15:0] negIn,
	input logic [15:0] negOut,
	output logic [4:0] expNorm,
	output logic [5:0] expOffset,
	input logic [15:0] expOut,
	output logic normReady,
	output logic [31:0] normIn,
	input logic normDone,
	input logic [4:0] normCount,
	input logic [31:0] normOut
);

	corrState state;
	corrState nextState;
	corrTerm term;
	logic [IDX_W-1:0] idx;
	logic lastSample;
	logic [ADDR_W-1:0] partnerBase;
	logic [ADDR_W-1:0] resultAddr;
	logic [31:0] acc;
	logic [15:0] y2Scaled;
	logic [15:0] mant;
	logic [15:0] expVal;

	assign lastSample = (idx == IDX_W'(SUBFRAME_LEN - 1));

	// Vector that gets multiplied with y2
	always_comb
	begin
		case (term)
			termXy: partnerBase = XN_BASE;
			termZy: partnerBase = Y1_BASE;
			default: partnerBase = Y2_BASE;
		endcase
	end

	// Two result words per term
	assign resultAddr = RESULT_BASE + ADDR_W'({term, 1'b0});

	//////////////////////////////
	// State sequencing
	//////////////////////////////

	always_comb
	begin
		nextState = state;
		case (state)
			idle: if (start) nextState = readPair;
			readPair: nextState = waitRead;
			waitRead: nextState = lastSample ? accumulate : readPair;
			accumulate: nextState = normStart;
			normStart: nextState = normWait;
			normWait: if (normDone) nextState = writeMant;
			writeMant: nextState = writeExp;
			writeExp: nextState = (term == termZy) ? finish : readPair;
			finish: nextState = idle;
			default: nextState = idle;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= idle;
			term <= termYy;
			idx <= '0;
		end
		else
		begin
			state <= nextState;
			if (state == idle && start)
			begin
				term <= termYy;
				idx <= '0;
			end
			else if (state == waitRead && !lastSample)
				idx <= idx + 1'b1;
			else if (state == writeExp)
			begin
				idx <= '0;
				case (term)
					termYy: term <= termXy;
					termXy: term <= termZy;
					default: term <= termYy;
				endcase
			end
		end
	end

	//////////////////////////////
	// Datapath registers
	//////////////////////////////

	// readPair sees the partner word of the previous sample
	always_ff @(posedge clk)
	begin
		case (state)
			idle: acc <= 32'd1;
			readPair:
			begin
				if (idx != '0)
					acc <= macOut;
			end
			waitRead: y2Scaled <= shrOut;
			accumulate: acc <= macOut;
			normWait:
			begin
				if (normDone)
				begin
					mant <= (term == termYy) ? normOut[31:16] : negOut;
					expVal <= expOut;
				end
			end
			writeExp: acc <= 32'd1;
			default: ;
		endcase
	end

	// Operator inputs
	assign shrIn = memReadData[15:0];
	assign macA = y2Scaled;
	// Energy term scales both factors
	assign macB = (term == termYy) ? shrOut : memReadData[15:0];
	assign macAcc = acc;
	assign negIn = normOut[31:16];
	assign expNorm = normCount;
	assign expOffset = (term == termYy) ? YY_EXP_OFFSET : CROSS_EXP_OFFSET;

	assign normIn = acc;
	assign normReady = (state == normStart);

	// y2 on readPair, partner on waitRead
	assign memReadAddr = (state == waitRead) ? partnerBase + ADDR_W'(idx)
		: Y2_BASE + ADDR_W'(idx);

	assign memWriteEn = (state == writeMant) || (state == writeExp);
	assign memWriteAddr = (state == writeExp) ? resultAddr + ADDR_W'(1) : resultAddr;
	assign memWriteData = (state == writeExp) ? {{16{expVal[15]}}, expVal}
		: {{16{mant[15]}}, mant};

	assign done = (state == finish);

endmodule

// ==== rtl/corrXy2Pipe.sv ====
`timescale 1ns/100ps

module corrXy2Pipe import corrPkg::*; (
	input logic clk,
	input logic arstN,
	input logic start,
	input logic memMuxSel,
	input logic [ADDR_W-1:0] testReadAddr,
	input logic [ADDR_W-1:0] testWriteAddr,
	input logic [DATA_W-1:0] testWriteData,
	input logic testWriteEn,
	output logic done,
	output logic [DATA_W-1:0] memData
);

	logic [ADDR_W-1:0] fsmReadAddr;
	logic [ADDR_W-1:0] fsmWriteAddr;
	logic [DATA_W-1:0] fsmWriteData;
	logic fsmWriteEn;
	logic [ADDR_W-1:0] readAddrMux;
	logic [ADDR_W-1:0] writeAddrMux;
	logic [DATA_W-1:0] writeDataMux;
	logic writeEnMux;
	logic [15:0] shrIn;
	logic [15:0] shrOut;
	logic [15:0] macA;
	logic [15:0] macB;
	logic [31:0] macAcc;
	logic [31:0] macOut;
	logic [15:0] negIn;
	logic [15:0] negOut;
	logic [4:0] expNorm;
	logic [5:0] expOffset;
	logic [15:0] expOut;
	logic normReady;
	logic [31:0] normIn;
	logic normDone;
	logic [4:0] normCount;
	logic [31:0] normOut;

	//////////////////////////////
	// Memory port muxes
	//////////////////////////////

	// Test port takes both memory ports when selected
	always_comb
	begin
		if (memMuxSel)
		begin
			readAddrMux = testReadAddr;
			writeAddrMux = testWriteAddr;
			writeDataMux = testWriteData;
			writeEnMux = testWriteEn;
		end
		else
		begin
			readAddrMux = fsmReadAddr;
			writeAddrMux = fsmWriteAddr;
			writeDataMux = fsmWriteData;
			writeEnMux = fsmWriteEn;
		end
	end

	scratchMemory scratchMem (
		.clk(clk),
		.writeAddr(writeAddrMux),
		.writeData(writeDataMux),
		.writeEn(writeEnMux),
		.readAddr(readAddrMux),
		.readData(memData)
	);

	corrXy2Fsm fsm (
		.clk(clk),
		.arstN(arstN),
		.start(start),
		.done(done),
		.memReadAddr(fsmReadAddr),
		.memWriteAddr(fsmWriteAddr),
		.memWriteData(fsmWriteData),
		.memWriteEn(fsmWriteEn),
		.memReadData(memData),
		.shrIn(shrIn),
		.shrOut(shrOut),
		.macA(macA),
		.macB(macB),
		.macAcc(macAcc),
		.macOut(macOut),
		.negIn(negIn),
		.negOut(negOut),
		.expNorm(expNorm),
		.expOffset(expOffset),
		.expOut(expOut),
		.normReady(normReady),
		.normIn(normIn),
		.normDone(normDone),
		.normCount(normCount),
		.normOut(normOut)
	);

	fractArith arith (
		.shrIn(shrIn),
		.shrOut(shrOut),
		.macA(macA),
		.macB(macB),
		.macAcc(macAcc),
		.macOut(macOut),
		.negIn(negIn),
		.negOut(negOut),
		.expNorm(expNorm),
		.expOffset(expOffset),
		.expOut(expOut)
	);

	normalizer norm (
		.clk(clk),
		.arstN(arstN),
		.normReady(normReady),
		.normIn(normIn),
		.normDone(normDone),
		.normCount(normCount),
		.normOut(normOut)
	);

endmodule

// ==== rtl/fractArith.sv ====
`timescale 1ns/100ps

module fractArith import corrPkg::*; (
	input logic [15:0] shrIn,
	output logic [15:0] shrOut,
	input logic [15:0] macA,
	input logic [15:0] macB,
	input logic [31:0] macAcc,
	output logic [31:0] macOut,
	input logic [15:0] negIn,
	output logic [15:0] negOut,
	input logic [4:0] expNorm,
	input logic [5:0] expOffset,
	output logic [15:0] expOut
);

	logic signed [31:0] product;
	logic signed [33:0] accWide;
	logic signed [33:0] prodTwice;
	logic signed [33:0] macSum;

	//////////////////////////////
	// Shift right
	//////////////////////////////

	// Arithmetic, so the sign is kept
	assign shrOut = $signed(shrIn) >>> Y2_SHIFT;

	//////////////////////////////
	// Multiply-accumulate
	//////////////////////////////

	assign product = $signed(macA) * $signed(macB);

	// Two guard bits above the 32-bit accumulator
	assign accWide = {{2{macAcc[31]}}, macAcc};
	assign prodTwice = {product[31], product, 1'b0};
	assign macSum = accWide + prodTwice;

	// Clamp when the guard bits disagree with bit 31
	always_comb
	begin
		if (macSum[33:31] == 3'b000 || macSum[33:31] == 3'b111)
			macOut = macSum[31:0];
		else if (macSum[33])
			macOut = 32'h8000_0000;
		else
			macOut = 32'h7fff_ffff;
	end

	//////////////////////////////
	// Negate and exponent
	//////////////////////////////

	// Most negative value has no positive twin
	assign negOut = (negIn == 16'h8000) ? 16'h7fff : -negIn;

	// Can go negative for small shift counts
	assign expOut = {11'd0, expNorm} - {10'd0, expOffset};

endmodule

// ==== rtl/normalizer.sv ====
`timescale 1ns/100ps

module normalizer (
	input logic clk,
	input logic arstN,
	input logic normReady,
	input logic [31:0] normIn,
	output logic normDone,
	output logic [4:0] normCount,
	output logic [31:0] normOut
);

	logic busy;
	logic stop;
	logic [31:0] work;
	logic [4:0] count;

	// Normalized once the two top bits differ; zero never gets there
	assign stop = (work == 32'd0) || (work[31] ^ work[30]);

	//////////////////////////////
	// Control
	//////////////////////////////

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			busy <= 1'b0;
			normDone <= 1'b0;
		end
		else
		begin
			normDone <= 1'b0;
			if (normReady)
				busy <= 1'b1;
			else if (busy && stop)
			begin
				busy <= 1'b0;
				normDone <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// Shifter
	//////////////////////////////

	// One bit per cycle, the count tracks the shifts made
	always_ff @(posedge clk)
	begin
		if (normReady)
		begin
			work <= normIn;
			count <= 5'd0;
		end
		else if (busy && !stop)
		begin
			work <= work << 1;
			count <= count + 5'd1;
		end
	end

	// Both hold still while normDone is high
	assign normOut = work;
	assign normCount = count;

endmodule

// ==== rtl/scratchMemory.sv ====
`timescale 1ns/100ps

module scratchMemory import corrPkg::*; (
	input logic clk,
	input logic [ADDR_W-1:0] writeAddr,
	input logic [DATA_W-1:0] writeData,
	input logic writeEn,
	input logic [ADDR_W-1:0] readAddr,
	output logic [DATA_W-1:0] readData
);

	// 4K words, inferred as block RAM
	logic [DATA_W-1:0] mem [0:(1 << ADDR_W) - 1];

	// Write port
	always_ff @(posedge clk)
	begin
		if (writeEn)
			mem[writeAddr] <= writeData;
	end

	// Registered read port, data one cycle after the address
	always_ff @(posedge clk)
	begin
		readData <= mem[readAddr];
	end

endmodule

// ==== sim.f ====
rtl/corrPkg.sv
rtl/scratchMemory.sv
rtl/fractArith.sv
rtl/normalizer.sv
rtl/corrXy2Fsm.sv
rtl/corrXy2Pipe.sv
bench/clockGen.sv
bench/corrXy2_properties.sv
bench/corrXy2Tb.sv
